// ==== hdl/bju_cond_if.sv ====
//====================
// condition stage to resolve stage
// taken is already forced for jal, jalr and auipc
//====================

`timescale 1ns/1ps

interface bju_cond_if;

  logic                       vld;
  bju_pkg::bju_inst_t         inst;
  logic                       taken;
  logic [bju_pkg::PC_W-1:0]   target_pc;
  logic [bju_pkg::PC_W-1:0]   inc_pc;

  modport src (
    output vld,
    output inst,
    output taken,
    output target_pc,
    output inc_pc
  );

  modport dst (
    input  vld,
    input  inst,
    input  taken,
    input  target_pc,
    input  inc_pc
  );

endinterface

// ==== hdl/bju_cond_stage.sv ====
//====================
// branch condition, target and incremented pc
// jalr target takes the low PC_W bits of src0 plus imm, bit 0 cleared
// results are registered together with the instruction
//====================

`timescale 1ns/1ps

module bju_cond_stage (
  input  logic          bju_entry_clk,
  input  logic          cpurst_b,
  input  logic          flush,
  bju_opnd_if.dst       opnd,
  bju_cond_if.src       cond
);

  logic                         src_eq;
  logic                         src_ltu;
  logic                         src_lts;
  logic                         taken;
  logic [bju_pkg::PC_W-1:0]     imm_ext;
  logic [bju_pkg::PC_W-1:0]     pc_rel_target;
  logic [bju_pkg::PC_W-1:0]     jalr_sum;
  logic [bju_pkg::PC_W-1:0]     target_pc;
  logic [bju_pkg::PC_W-1:0]     inc_step;
  logic [bju_pkg::PC_W-1:0]     inc_pc;

  //====================
  // comparator
  //====================
  assign src_eq  = (opnd.src0 == opnd.src1);
  assign src_ltu = (opnd.src0 < opnd.src1);
  assign src_lts = ($signed(opnd.src0) < $signed(opnd.src1));

  always_comb
  begin
    case (opnd.inst.op)
      bju_pkg::OP_BEQ:   taken = src_eq;
      bju_pkg::OP_BNE:   taken = !src_eq;
      bju_pkg::OP_BLT:   taken = src_lts;
      bju_pkg::OP_BGE:   taken = !src_lts;
      bju_pkg::OP_BLTU:  taken = src_ltu;
      bju_pkg::OP_BGEU:  taken = !src_ltu;
      // unconditional jumps always leave the sequential path
      bju_pkg::OP_JAL:   taken = 1'b1;
      bju_pkg::OP_JALR:  taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  //====================
  // adders
  //====================
  assign imm_ext = {{(bju_pkg::PC_W - bju_pkg::IMM_W){opnd.inst.imm[bju_pkg::IMM_W-1]}},
                    opnd.inst.imm};

  // branches, jal and auipc are pc relative
  assign pc_rel_target = opnd.inst.pc + imm_ext;

  // upper src0 bits fall outside the address space
  assign jalr_sum = opnd.src0[bju_pkg::PC_W-1:0] + imm_ext;

  assign target_pc = (opnd.inst.op == bju_pkg::OP_JALR) ? {jalr_sum[bju_pkg::PC_W-1:1], 1'b0}
                                                         : pc_rel_target;

  // plus 4 for 32-bit, plus 2 for compressed
  assign inc_step = opnd.inst.inst_len ? bju_pkg::PC_W'(4) : bju_pkg::PC_W'(2);
  assign inc_pc   = opnd.inst.pc + inc_step;

  //====================
  // condition register
  //====================
  always_ff @(posedge bju_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cond.vld <= 1'b0;
    else
      cond.vld <= opnd.vld && !flush;
  end

  always_ff @(posedge bju_entry_clk)
  begin
    if (opnd.vld)
    begin
      cond.inst      <= opnd.inst;
      cond.taken     <= taken;
      cond.target_pc <= target_pc;
      cond.inc_pc    <= inc_pc;
    end
  end

endmodule

// ==== hdl/bju_operand_stage.sv ====
//====================
// issue register of the unit
// a load result in the issue cycle bypasses onto a matching source
// register x0 never matches, flush drops the issue of that cycle
//====================

`timescale 1ns/1ps

module bju_operand_stage (
  input  logic                          bju_entry_clk,
  input  logic                          cpurst_b,
  input  logic                          issue_vld,
  input  bju_pkg::bju_inst_t            issue_inst,
  input  logic [bju_pkg::XLEN-1:0]      issue_src0,
  input  logic [bju_pkg::XLEN-1:0]      issue_src1,
  input  logic [bju_pkg::REG_W-1:0]     issue_src0_reg,
  input  logic [bju_pkg::REG_W-1:0]     issue_src1_reg,
  input  logic                          fwd_vld,
  input  logic [bju_pkg::REG_W-1:0]     fwd_reg,
  input  logic [bju_pkg::XLEN-1:0]      fwd_data,
  input  logic                          flush,
  bju_opnd_if.src                       opnd
);

  logic                         fwd_nonzero;
  logic                         src0_fwd_hit;
  logic                         src1_fwd_hit;
  logic [bju_pkg::XLEN-1:0]     src0_byp;
  logic [bju_pkg::XLEN-1:0]     src1_byp;

  //====================
  // load data bypass
  //====================
  // x0 is hardwired, a write to it carries nothing
  assign fwd_nonzero  = (fwd_reg != '0);
  assign src0_fwd_hit = fwd_vld && fwd_nonzero && (fwd_reg == issue_src0_reg);
  assign src1_fwd_hit = fwd_vld && fwd_nonzero && (fwd_reg == issue_src1_reg);

  assign src0_byp = src0_fwd_hit ? fwd_data : issue_src0;
  assign src1_byp = src1_fwd_hit ? fwd_data : issue_src1;

  //====================
  // issue register
  //====================
  always_ff @(posedge bju_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      opnd.vld <= 1'b0;
    else
      opnd.vld <= issue_vld && !flush;
  end

  // payload, loaded only on a real issue
  always_ff @(posedge bju_entry_clk)
  begin
    if (issue_vld)
    begin
      opnd.inst <= issue_inst;
      opnd.src0 <= src0_byp;
      opnd.src1 <= src1_byp;
    end
  end

endmodule

// ==== hdl/bju_opnd_if.sv ====
//====================
// operand stage to condition stage
// vld is a one-cycle qualifier, no back-pressure
//====================

`timescale 1ns/1ps

interface bju_opnd_if;

  logic                       vld;
  bju_pkg::bju_inst_t         inst;
  // operands after load-data bypass
  logic [bju_pkg::XLEN-1:0]   src0;
  logic [bju_pkg::XLEN-1:0]   src1;

  modport src (
    output vld,
    output inst,
    output src0,
    output src1
  );

  modport dst (
    input  vld,
    input  inst,
    input  src0,
    input  src1
  );

endinterface

// ==== hdl/bju_pkg.sv ====
//====================
// shared widths and types for the branch and jump unit
// widths are fixed architectural constants, the struct depends on them
// pc is 40 bits, only the low PC_W bits of a register operand form a jump target
//====================

package bju_pkg;

  //====================
  // widths
  //====================
  // register data width
  localparam int XLEN  = 64;
  // instruction address width
  localparam int PC_W  = 40;
  // register index width
  localparam int REG_W = 5;
  // captured immediate, sign-extended inside the unit
  localparam int IMM_W = 21;

  //====================
  // opcodes
  //====================
  typedef enum logic [3:0] {
    OP_BEQ   = 4'h0,
    OP_BNE   = 4'h1,
    OP_BLT   = 4'h2,
    OP_BGE   = 4'h3,
    OP_BLTU  = 4'h4,
    OP_BGEU  = 4'h5,
    OP_JAL   = 4'h6,
    OP_JALR  = 4'h7,
    OP_AUIPC = 4'h8
  } bju_op_e;

  // per-instruction fields carried down the pipe
  typedef struct packed {
    bju_op_e              op;
    logic [PC_W-1:0]      pc;
    logic [IMM_W-1:0]     imm;
    // 1 = 32-bit instruction, 0 = 16-bit
    logic                 inst_len;
    // bht prediction from the front end
    logic                 pred_taken;
    logic [PC_W-1:0]      pred_pc;
    logic [REG_W-1:0]     dst_reg;
  } bju_inst_t;

endpackage

// ==== hdl/bju_resolve_stage.sv ====
//====================
// checks the outcome against the front end prediction
// every output is registered and valid for one cycle
// flush is the registered redirect and also drops this stage's input
//====================

`timescale 1ns/1ps

module bju_resolve_stage (
  input  logic                          bju_entry_clk,
  input  logic                          cpurst_b,
  bju_cond_if.dst                       cond,
  output logic                          flush,
  output logic                          cmplt_vld,
  output logic [bju_pkg::PC_W-1:0]      cmplt_pc,
  output logic                          redirect_vld,
  output logic [bju_pkg::PC_W-1:0]      redirect_pc,
  output logic                          bht_vld,
  output logic                          bht_taken,
  output logic                          bht_mispred,
  output logic                          wb_vld,
  output logic [bju_pkg::REG_W-1:0]     wb_reg,
  output logic [bju_pkg::XLEN-1:0]      wb_data
);

  logic                         in_vld;
  logic                         is_condbr;
  logic                         is_jump;
  logic                         is_jalr;
  logic                         is_auipc;
  logic                         dst_nonzero;
  logic                         br_mispred;
  logic                         jalr_mispred;
  logic                         redirect_nxt;
  logic [bju_pkg::PC_W-1:0]     redirect_pc_nxt;
  logic                         wb_nxt;
  logic [bju_pkg::PC_W-1:0]     wb_pc;

  // the instruction right behind a redirect is younger, drop it
  assign in_vld = cond.vld && !flush;

  //====================
  // decode
  //====================
  assign is_condbr = (cond.inst.op == bju_pkg::OP_BEQ)  || (cond.inst.op == bju_pkg::OP_BNE)  ||
                     (cond.inst.op == bju_pkg::OP_BLT)  || (cond.inst.op == bju_pkg::OP_BGE)  ||
                     (cond.inst.op == bju_pkg::OP_BLTU) || (cond.inst.op == bju_pkg::OP_BGEU);
  assign is_jalr   = (cond.inst.op == bju_pkg::OP_JALR);
  assign is_jump   = (cond.inst.op == bju_pkg::OP_JAL) || is_jalr;
  assign is_auipc  = (cond.inst.op == bju_pkg::OP_AUIPC);
  assign dst_nonzero = (cond.inst.dst_reg != '0);

  //====================
  // mispredict check
  //====================
  assign br_mispred   = is_condbr && (cond.taken != cond.inst.pred_taken);
  // jal target is known to the front end, never redirects
  assign jalr_mispred = is_jalr && (cond.target_pc != cond.inst.pred_pc);
  assign redirect_nxt = in_vld && (br_mispred || jalr_mispred);

  // taken branch or jalr goes to target, not-taken falls through
  assign redirect_pc_nxt = cond.taken ? cond.target_pc : cond.inc_pc;

  //====================
  // writeback
  //====================
  assign wb_nxt = in_vld && dst_nonzero && (is_jump || is_auipc);
  // link address for jumps, pc plus imm for auipc
  assign wb_pc  = is_auipc ? cond.target_pc : cond.inc_pc;

  //====================
  // output registers
  //====================
  always_ff @(posedge bju_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cmplt_vld    <= 1'b0;
      redirect_vld <= 1'b0;
      bht_vld      <= 1'b0;
      wb_vld       <= 1'b0;
    end
    else
    begin
      cmplt_vld    <= in_vld;
      redirect_vld <= redirect_nxt;
      bht_vld      <= in_vld && is_condbr;
      wb_vld       <= wb_nxt;
    end
  end

  always_ff @(posedge bju_entry_clk)
  begin
    if (in_vld)
    begin
      cmplt_pc    <= cond.inst.pc;
      redirect_pc <= redirect_pc_nxt;
      bht_taken   <= cond.taken;
      bht_mispred <= br_mispred;
      wb_reg      <= cond.inst.dst_reg;
      wb_data     <= {{(bju_pkg::XLEN - bju_pkg::PC_W){1'b0}}, wb_pc};
    end
  end

  assign flush = redirect_vld;

endmodule

// ==== hdl/bju_top.sv ====
//====================
// branch and jump unit, three stages, one issue per cycle
// results appear three edges after issue, no back-pressure
// a redirect drops the three younger issues still in flight
//====================

`timescale 1ns/1ps

module bju_top (
  input  logic                          bju_entry_clk,
  input  logic                          cpurst_b,
  // issue
  input  logic                          issue_vld,
  input  bju_pkg::bju_op_e              issue_op,
  input  logic [bju_pkg::PC_W-1:0]      issue_pc,
  input  logic [bju_pkg::IMM_W-1:0]     issue_imm,
  input  logic                          issue_inst_len,
  input  logic                          issue_pred_taken,
  input  logic [bju_pkg::PC_W-1:0]      issue_pred_pc,
  input  logic [bju_pkg::REG_W-1:0]     issue_dst_reg,
  input  logic [bju_pkg::XLEN-1:0]      issue_src0,
  input  logic [bju_pkg::XLEN-1:0]      issue_src1,
  input  logic [bju_pkg::REG_W-1:0]     issue_src0_reg,
  input  logic [bju_pkg::REG_W-1:0]     issue_src1_reg,
  // load result forward
  input  logic                          fwd_vld,
  input  logic [bju_pkg::REG_W-1:0]     fwd_reg,
  input  logic [bju_pkg::XLEN-1:0]      fwd_data,
  // results
  output logic                          cmplt_vld,
  output logic [bju_pkg::PC_W-1:0]      cmplt_pc,
  output logic                          redirect_vld,
  output logic [bju_pkg::PC_W-1:0]      redirect_pc,
  output logic                          bht_vld,
  output logic                          bht_taken,
  output logic                          bht_mispred,
  output logic                          wb_vld,
  output logic [bju_pkg::REG_W-1:0]     wb_reg,
  output logic [bju_pkg::XLEN-1:0]      wb_data
);

  bju_pkg::bju_inst_t   issue_inst;
  logic                 flush;

  bju_opnd_if           opnd_if ();
  bju_cond_if           cond_if ();

  // pack the issued fields into the pipeline struct
  always_comb
  begin
    issue_inst.op         = issue_op;
    issue_inst.pc         = issue_pc;
    issue_inst.imm        = issue_imm;
    issue_inst.inst_len   = issue_inst_len;
    issue_inst.pred_taken = issue_pred_taken;
    issue_inst.pred_pc    = issue_pred_pc;
    issue_inst.dst_reg    = issue_dst_reg;
  end

  //====================
  // stages
  //====================
  bju_operand_stage u_operand_stage (
    .bju_entry_clk  (bju_entry_clk),
    .cpurst_b       (cpurst_b),
    .issue_vld      (issue_vld),
    .issue_inst     (issue_inst),
    .issue_src0     (issue_src0),
    .issue_src1     (issue_src1),
    .issue_src0_reg (issue_src0_reg),
    .issue_src1_reg (issue_src1_reg),
    .fwd_vld        (fwd_vld),
    .fwd_reg        (fwd_reg),
    .fwd_data       (fwd_data),
    .flush          (flush),
    .opnd           (opnd_if.src)
  );

  bju_cond_stage u_cond_stage (
    .bju_entry_clk  (bju_entry_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .opnd           (opnd_if.dst),
    .cond           (cond_if.src)
  );

  bju_resolve_stage u_resolve_stage (
    .bju_entry_clk  (bju_entry_clk),
    .cpurst_b       (cpurst_b),
    .cond           (cond_if.dst),
    .flush          (flush),
    .cmplt_vld      (cmplt_vld),
    .cmplt_pc       (cmplt_pc),
    .redirect_vld   (redirect_vld),
    .redirect_pc    (redirect_pc),
    .bht_vld        (bht_vld),
    .bht_taken      (bht_taken),
    .bht_mispred    (bht_mispred),
    .wb_vld         (wb_vld),
    .wb_reg         (wb_reg),
    .wb_data        (wb_data)
  );

endmodule

// ==== tests/bju_props.sv ====
//====================
// result protocol properties, bound into bju_top
// sampled on the rising clock, off during reset
//====================

`timescale 1ns/1ps

module bju_props (
  input logic                        bju_entry_clk,
  input logic                        cpurst_b,
  input logic                        cmplt_vld,
  input logic                        redirect_vld,
  input logic                        wb_vld,
  input logic [bju_pkg::REG_W-1:0]   wb_reg
);

  // a redirect always belongs to a completing instruction
  redirect_has_cmplt: assert property (@(posedge bju_entry_clk) disable iff (!cpurst_b)
    redirect_vld |-> cmplt_vld)
    else $error("redirect_vld high without cmplt_vld");

  // the flush drops the next instruction, so no back-to-back redirect
  redirect_single: assert property (@(posedge bju_entry_clk) disable iff (!cpurst_b)
    redirect_vld |=> !redirect_vld)
    else $error("redirect_vld high on two consecutive cycles");

  wb_not_x0: assert property (@(posedge bju_entry_clk) disable iff (!cpurst_b)
    wb_vld |-> (wb_reg != '0))
    else $error("writeback to register zero");

endmodule

bind bju_top bju_props u_props (
  .bju_entry_clk (bju_entry_clk),
  .cpurst_b      (cpurst_b),
  .cmplt_vld     (cmplt_vld),
  .redirect_vld  (redirect_vld),
  .wb_vld        (wb_vld),
  .wb_reg        (wb_reg)
);

// ==== tests/bju_tb_model.svh ====
//====================
// expected results of the branch and jump unit
// included inside the testbench module, uses its clock-free state only
//====================

`ifndef BJU_TB_MODEL_SVH
`define BJU_TB_MODEL_SVH

// one expected completion
typedef struct {
  int                           due;
  logic [bju_pkg::PC_W-1:0]     pc;
  logic                         redirect;
  logic [bju_pkg::PC_W-1:0]     redirect_pc;
  logic                         bht_vld;
  logic                         bht_taken;
  logic                         bht_mispred;
  logic                         wb_vld;
  logic [bju_pkg::REG_W-1:0]    wb_reg;
  logic [bju_pkg::XLEN-1:0]     wb_data;
} exp_t;

exp_t exp_q[$];

// register plus immediate, low bit dropped, cut to the address width
function automatic logic [bju_pkg::PC_W-1:0] jalr_target(
  input logic [bju_pkg::XLEN-1:0]  s0,
  input logic [bju_pkg::IMM_W-1:0] imm
);
  logic [bju_pkg::XLEN-1:0] sum;
  sum    = s0 + {{(bju_pkg::XLEN-bju_pkg::IMM_W){imm[bju_pkg::IMM_W-1]}}, imm};
  sum[0] = 1'b0;
  return sum[bju_pkg::PC_W-1:0];
endfunction

function automatic exp_t predict(
  input bju_pkg::bju_op_e           op,
  input logic [bju_pkg::PC_W-1:0]   pc,
  input logic [bju_pkg::IMM_W-1:0]  imm,
  input logic                       inst_len,
  input logic                       pred_taken,
  input logic [bju_pkg::PC_W-1:0]   pred_pc,
  input logic [bju_pkg::REG_W-1:0]  dst_reg,
  input logic [bju_pkg::XLEN-1:0]   s0,
  input logic [bju_pkg::XLEN-1:0]   s1
);
  exp_t                        e;
  logic [bju_pkg::XLEN-1:0]    rel_sum;
  logic [bju_pkg::PC_W-1:0]    inc;
  logic [bju_pkg::PC_W-1:0]    tgt;
  logic                        t;
  logic                        cond_br;
  rel_sum = pc + {{(bju_pkg::XLEN-bju_pkg::IMM_W){imm[bju_pkg::IMM_W-1]}}, imm};
  inc     = pc + (inst_len ? 4 : 2);
  tgt     = (op == bju_pkg::OP_JALR) ? jalr_target(s0, imm) : rel_sum[bju_pkg::PC_W-1:0];
  case (op)
    bju_pkg::OP_BEQ:   t = (s0 == s1);
    bju_pkg::OP_BNE:   t = (s0 != s1);
    bju_pkg::OP_BLT:   t = ($signed(s0) < $signed(s1));
    bju_pkg::OP_BGE:   t = ($signed(s0) >= $signed(s1));
    bju_pkg::OP_BLTU:  t = (s0 < s1);
    bju_pkg::OP_BGEU:  t = (s0 >= s1);
    bju_pkg::OP_AUIPC: t = 1'b0;
    default:           t = 1'b1;
  endcase
  cond_br = op inside {bju_pkg::OP_BEQ, bju_pkg::OP_BNE, bju_pkg::OP_BLT,
                       bju_pkg::OP_BGE, bju_pkg::OP_BLTU, bju_pkg::OP_BGEU};
  e.due         = 0;
  e.pc          = pc;
  e.bht_vld     = cond_br;
  e.bht_taken   = t;
  e.bht_mispred = cond_br && (t != pred_taken);
  e.redirect    = e.bht_mispred || ((op == bju_pkg::OP_JALR) && (tgt != pred_pc));
  e.redirect_pc = t ? tgt : inc;
  e.wb_vld      = (dst_reg != 0) && (op inside {bju_pkg::OP_JAL, bju_pkg::OP_JALR,
                                                bju_pkg::OP_AUIPC});
  e.wb_reg      = dst_reg;
  e.wb_data     = (op == bju_pkg::OP_AUIPC) ? tgt : inc;
  return e;
endfunction

`endif

// ==== tests/bju_tb.sv ====
//====================
// random testbench for bju_top
// inputs change 2 ns after the rising edge, outputs are read on the falling edge
//====================

`timescale 1ns/1ps

module bju_tb;

  localparam int          CLK_PERIOD      = 40;
  localparam int          NUM_INST        = 400;
  localparam int          WATCHDOG_CYCLES = 16 + 4 * NUM_INST + 20;
  localparam int unsigned SEED            = 32'hc0ab5ee8;

  logic                          bju_entry_clk;
  logic                          cpurst_b;
  logic                          issue_vld;
  bju_pkg::bju_op_e              issue_op;
  logic [bju_pkg::PC_W-1:0]      issue_pc;
  logic [bju_pkg::IMM_W-1:0]     issue_imm;
  logic                          issue_inst_len;
  logic                          issue_pred_taken;
  logic [bju_pkg::PC_W-1:0]      issue_pred_pc;
  logic [bju_pkg::REG_W-1:0]     issue_dst_reg;
  logic [bju_pkg::XLEN-1:0]      issue_src0;
  logic [bju_pkg::XLEN-1:0]      issue_src1;
  logic [bju_pkg::REG_W-1:0]     issue_src0_reg;
  logic [bju_pkg::REG_W-1:0]     issue_src1_reg;
  logic                          fwd_vld;
  logic [bju_pkg::REG_W-1:0]     fwd_reg;
  logic [bju_pkg::XLEN-1:0]      fwd_data;
  logic                          cmplt_vld;
  logic [bju_pkg::PC_W-1:0]      cmplt_pc;
  logic                          redirect_vld;
  logic [bju_pkg::PC_W-1:0]      redirect_pc;
  logic                          bht_vld;
  logic                          bht_taken;
  logic                          bht_mispred;
  logic                          wb_vld;
  logic [bju_pkg::REG_W-1:0]     wb_reg;
  logic [bju_pkg::XLEN-1:0]      wb_data;

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          drop_slots = 0;
  int unsigned seed_init;

  `include "bju_tb_model.svh"

  bju_top UUT (.*);

  initial
  begin
    bju_entry_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bju_entry_clk = ~bju_entry_clk;
  end

  always @(posedge bju_entry_clk)
    cyc <= cyc + 1;

  //====================
  // stimulus helpers
  //====================
  // zero, sign boundaries, all ones, one or random
  function automatic logic [bju_pkg::XLEN-1:0] pick_operand();
    case ($urandom_range(5))
      0:       return '0;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'h7fff_ffff_ffff_ffff;
      3:       return '1;
      4:       return 64'h1;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic logic [bju_pkg::XLEN-1:0] apply_forward(
    input logic [bju_pkg::XLEN-1:0]  data,
    input logic [bju_pkg::REG_W-1:0] src_reg
  );
    return (fwd_vld && (fwd_reg != 0) && (fwd_reg == src_reg)) ? fwd_data : data;
  endfunction

  task automatic drive_idle();
    issue_vld        = 1'b0;
    issue_op         = bju_pkg::OP_BEQ;
    issue_pc         = '0;
    issue_imm        = '0;
    issue_inst_len   = 1'b1;
    issue_pred_taken = 1'b0;
    issue_pred_pc    = '0;
    issue_dst_reg    = '0;
    issue_src0       = '0;
    issue_src1       = '0;
    issue_src0_reg   = '0;
    issue_src1_reg   = '0;
    fwd_vld          = 1'b0;
    fwd_reg          = '0;
    fwd_data         = '0;
  endtask

  task automatic drive_issue();
    logic [31:0]                 r;
    logic [bju_pkg::XLEN-1:0]    s0_eff;
    logic [bju_pkg::XLEN-1:0]    s1_eff;
    logic                        dropped;
    exp_t                        e;
    r                = $urandom;
    issue_vld        = ($urandom_range(7) != 0);
    issue_op         = bju_pkg::bju_op_e'($urandom_range(8));
    issue_pc         = {8'($urandom), r[31:1], 1'b0};
    issue_imm        = bju_pkg::IMM_W'($urandom);
    issue_inst_len   = 1'($urandom_range(1));
    issue_pred_taken = 1'($urandom_range(1));
    issue_pred_pc    = {8'($urandom), $urandom};
    issue_dst_reg    = ($urandom_range(3) == 0) ? '0 : bju_pkg::REG_W'($urandom);
    // few source registers so the forward often matches, x0 included
    issue_src0_reg   = bju_pkg::REG_W'($urandom_range(3));
    issue_src1_reg   = bju_pkg::REG_W'($urandom_range(3));
    issue_src0       = pick_operand();
    issue_src1       = ($urandom_range(3) == 0) ? issue_src0 : pick_operand();
    fwd_vld          = ($urandom_range(2) == 0);
    fwd_reg          = bju_pkg::REG_W'($urandom_range(3));
    fwd_data         = pick_operand();
    s0_eff = apply_forward(issue_src0, issue_src0_reg);
    s1_eff = apply_forward(issue_src1, issue_src1_reg);
    // half of the jalr get a correct prediction
    if ((issue_op == bju_pkg::OP_JALR) && ($urandom_range(1) == 0))
      issue_pred_pc = jalr_target(s0_eff, issue_imm);
    // three issue slots after a redirect are flushed
    dropped = (drop_slots != 0);
    if (dropped)
      drop_slots--;
    if (issue_vld && !dropped)
    begin
      e = predict(issue_op, issue_pc, issue_imm, issue_inst_len, issue_pred_taken,
                  issue_pred_pc, issue_dst_reg, s0_eff, s1_eff);
      e.due = cyc + 3;
      exp_q.push_back(e);
      if (e.redirect)
        drop_slots = 3;
    end
  endtask

  task automatic check_value(
    input string                    name,
    input logic [bju_pkg::XLEN-1:0] got,
    input logic [bju_pkg::XLEN-1:0] want
  );
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, want);
    end
  endtask

  //====================
  // compare
  //====================
  always @(negedge bju_entry_clk)
  begin : compare
    exp_t e;
    if (cmplt_vld)
    begin
      checks++;
      assert (exp_q.size() != 0)
      else
      begin
        errors++;
        $display("completion at pc %h with no instruction outstanding", cmplt_pc);
      end
      if (exp_q.size() != 0)
      begin
        e = exp_q.pop_front();
        checks++;
        assert (cyc == e.due)
        else
        begin
          errors++;
          $display("completion of pc %h came in cycle %0d instead of %0d", e.pc, cyc, e.due);
        end
        check_value("cmplt_pc", cmplt_pc, e.pc);
        check_value("redirect_vld", redirect_vld, e.redirect);
        if (e.redirect)
          check_value("redirect_pc", redirect_pc, e.redirect_pc);
        check_value("bht_vld", bht_vld, e.bht_vld);
        if (e.bht_vld)
        begin
          check_value("bht_taken", bht_taken, e.bht_taken);
          check_value("bht_mispred", bht_mispred, e.bht_mispred);
        end
        check_value("wb_vld", wb_vld, e.wb_vld);
        if (e.wb_vld)
        begin
          check_value("wb_reg", wb_reg, e.wb_reg);
          check_value("wb_data", wb_data, e.wb_data);
        end
      end
    end
    // the time zero clock step is no real edge
    else if (cyc != 0)
    begin
      checks++;
      assert (!cmplt_vld && !redirect_vld && !bht_vld && !wb_vld)
      else
      begin
        errors++;
        $display("result valid high or unknown without a completion in cycle %0d", cyc);
      end
    end
  end

  //====================
  // main sequence
  //====================
  initial
  begin
    seed_init = $urandom(SEED);
    drive_idle();
    cpurst_b = 1'b0;
    repeat (16) @(posedge bju_entry_clk);
    #2;
    cpurst_b = 1'b1;
    for (int i = 0; i < NUM_INST; i++)
    begin
      @(posedge bju_entry_clk);
      #2;
      drive_issue();
    end
    @(posedge bju_entry_clk);
    #2;
    drive_idle();
    // drain the pipe, then step off the compare edge
    repeat (8) @(posedge bju_entry_clk);
    #10;
    checks++;
    assert (exp_q.size() == 0)
    else
    begin
      errors++;
      $display("%0d expected completions never arrived", exp_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
hdl/bju_pkg.sv
hdl/bju_opnd_if.sv
hdl/bju_cond_if.sv
hdl/bju_operand_stage.sv
hdl/bju_cond_stage.sv
hdl/bju_resolve_stage.sv
hdl/bju_top.sv
tests/bju_props.sv
tests/bju_tb.sv
